/* files.f */
+incdir+design
design/decomp_pkg.sv
design/decomp_stream_if.sv
design/pipe_stage.sv
design/closest_rep_round.sv
design/chunk_gather.sv
design/balseq_lanes.sv
design/decomp_ctrl.sv
design/decomp_top.sv
test/tb_decomp_top.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_decomp_top \
  -o sim_decomp > run.log 2>&1 &&
  ./obj_dir/sim_decomp >> run.log 2>&1 ||
  echo "TEST FAILED (build or simulation error)" >> run.log
cat run.log
grep -q "TEST FAILED" run.log && exit 1 || exit 0

/* test/tb_decomp_top.sv */
`include "decomp_settings.svh"

module tb_decomp_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MOD_Q_W  = `DECOMP_MOD_Q_W;
  localparam int B_W      = `DECOMP_B_W;
  localparam int L        = `DECOMP_L;
  localparam int CHUNK_NB = `DECOMP_CHUNK_NB;
  localparam int COEF_NB  = `DECOMP_COEF_NB;
  localparam int ID_W     = `DECOMP_ID_W;
  localparam int REP_W    = L * B_W;
  localparam int BEAT_NB  = COEF_NB / CHUNK_NB;
  localparam int HALF     = 2 ** (B_W - 1);
  localparam int BASE     = 2 ** B_W;
  localparam int TIMEOUT  = 1000;

  typedef logic [COEF_NB-1:0][MOD_Q_W-1:0] coefs_t;
  typedef logic [COEF_NB-1:0][B_W:0]       digits_t;

  typedef struct packed {
    digits_t                       digits;
    logic                          sol;
    logic                          eol;
    logic [ID_W-1:0]               id;
    logic                          eob;
    logic [COEF_NB-1:0][REP_W-1:0] rep;
  } exp_level_t;

  logic                             clk;
  logic                             s_rst_n;
  logic                             in_valid_i;
  logic                             in_ready_o;
  logic [BEAT_NB-1:0][MOD_Q_W-1:0]  in_data_i;
  logic [ID_W-1:0]                  in_id_i;
  logic                             in_eob_i;
  logic                             out_valid_o;
  logic                             out_ready_i;
  digits_t                          out_data_o;
  logic                             out_sol_o;
  logic                             out_eol_o;
  logic [ID_W-1:0]                  out_id_o;
  logic                             out_eob_o;

  exp_level_t  exp_q[$];
  logic [31:0] lfsr_q = 32'h122359b3;
  int          cyc = 0;
  // Stream mode state shared by the driver and the compare process
  logic        gaps_on = 1'b0;
  logic        bp_on = 1'b0;
  logic        lat_arm = 1'b0;
  int          lat_ref = 0;
  logic        stream_chk = 1'b0;
  logic        stream_seen = 1'b0;
  int          stream_left = 0;

  decomp_top u_dut (.*);

  initial begin : clk_gen
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ====================
  // Helpers
  // ====================

  task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Reference model that queues the L levels of one block
  function automatic void expect_block(coefs_t coefs, logic [ID_W-1:0] id, logic eob);
    exp_level_t lvl [L];
    int rep;
    int carry;
    int v;
    int nbit;
    int digit;
    for (int i = 0; i < COEF_NB; i++) begin
      rep = (int'(coefs[i] >> (MOD_Q_W - REP_W)) + int'(coefs[i][MOD_Q_W-REP_W-1]))
            % (1 << REP_W);
      carry = 0;
      for (int k = 0; k < L; k++) begin
        v     = ((rep >> (k * B_W)) % BASE) + carry;
        nbit  = (k < L - 1) ? ((rep >> ((k + 2) * B_W - 1)) & 1) : 0;
        if (v > HALF || (v == HALF && nbit == 1)) begin
          digit = v - BASE;
          carry = 1;
        end else begin
          digit = v;
          carry = 0;
        end
        lvl[k].digits[i] = (B_W+1)'(digit);
        lvl[k].rep[i]    = REP_W'(rep);
      end
    end
    for (int k = 0; k < L; k++) begin
      lvl[k].sol = (k == 0);
      lvl[k].eol = (k == L - 1);
      lvl[k].id  = id;
      lvl[k].eob = eob;
      exp_q.push_back(lvl[k]);
    end
  endfunction

  // Sends one block beat by beat from 1 ns after a rising edge
  task automatic send_block(coefs_t coefs, logic [ID_W-1:0] id, logic eob);
    int   wait_cnt;
    logic hs;
    expect_block(coefs, id, eob);
    for (int b = 0; b < CHUNK_NB; b++) begin
      if (gaps_on) begin
        repeat (rand_bits(2)) begin
          in_valid_i = 1'b0;
          @(posedge clk);
          #1;
        end
      end
      in_valid_i = 1'b1;
      for (int j = 0; j < BEAT_NB; j++) begin
        in_data_i[j] = coefs[b * BEAT_NB + j];
      end
      // Earlier beats carry a different sideband
      in_id_i  = (b == CHUNK_NB - 1) ? id : ~id;
      in_eob_i = (b == CHUNK_NB - 1) ? eob : ~eob;
      wait_cnt = 0;
      hs = 1'b0;
      while (!hs) begin
        @(negedge clk);
        hs = in_ready_o;
        // Edge count once the last beat has transferred
        if (hs && lat_arm && b == CHUNK_NB - 1) begin
          lat_ref = cyc + 1;
          lat_arm = 1'b0;
        end
        @(posedge clk);
        #1;
        wait_cnt++;
        if (!hs && wait_cnt > TIMEOUT) abort_run("timeout waiting for in_ready_o");
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_random_block();
    coefs_t c;
    for (int i = 0; i < COEF_NB; i++) begin
      c[i] = rand_bits(32);
    end
    send_block(c, ID_W'(rand_bits(ID_W)), rand_bits(1) != 0);
  endtask

  task automatic wait_drained();
    int wait_cnt = 0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) abort_run("timeout waiting for the expected levels");
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  // ====================
  // Output side
  // ====================

  initial begin : ready_drive
    logic nxt;
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk);
      nxt = bp_on ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk);
      #1;
      out_ready_i = nxt;
    end
  end

  initial begin : compare_proc
    exp_level_t e;
    int         acc [COEF_NB];
    int         lvl_idx;
    int         d;
    int         sum;
    lvl_idx = 0;
    forever begin
      @(negedge clk);
      if (stream_chk && !stream_seen && out_valid_o) begin
        assert (cyc - lat_ref == 4) else value_error("first level latency", cyc - lat_ref, 4);
        stream_seen = 1'b1;
      end
      if (stream_chk && stream_seen && stream_left > 0) begin
        assert (out_valid_o) else abort_run("gap in the output level stream");
      end
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() > 0) else abort_run("output level with no block pending");
        e = exp_q.pop_front();
        assert (out_data_o === e.digits) else value_error("out_data_o", out_data_o, e.digits);
        assert (out_sol_o === e.sol) else value_error("out_sol_o", out_sol_o, e.sol);
        assert (out_eol_o === e.eol) else value_error("out_eol_o", out_eol_o, e.eol);
        assert (out_id_o === e.id) else value_error("out_id_o", out_id_o, e.id);
        assert (out_eob_o === e.eob) else value_error("out_eob_o", out_eob_o, e.eob);
        // Balanced range and weighted sum per lane
        for (int i = 0; i < COEF_NB; i++) begin
          d = $signed(out_data_o[i]);
          assert (d >= -HALF && d <= HALF) else abort_run("digit outside the balanced range");
          if (lvl_idx == 0) acc[i] = 0;
          acc[i] = acc[i] + d * (1 << (B_W * lvl_idx));
          if (lvl_idx == L - 1) begin
            sum = ((acc[i] % (1 << REP_W)) + (1 << REP_W)) % (1 << REP_W);
            assert (sum == int'(e.rep[i]))
              else value_error("out_data_o weighted sum", sum, e.rep[i]);
          end
        end
        lvl_idx = (lvl_idx == L - 1) ? 0 : lvl_idx + 1;
        if (stream_chk && stream_left > 0) stream_left--;
      end
    end
  end

  // ====================
  // Test sequence
  // ====================

  initial begin : main_proc
    coefs_t c;
    s_rst_n    = 1'b0;
    in_valid_i = 1'b0;
    in_data_i  = '0;
    in_id_i    = '0;
    in_eob_i   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid_o && in_ready_o)
      else abort_run("out_valid_o high or in_ready_o low after reset");
    @(posedge clk);
    #1;

    // Rounding up, wrap to zero, ties at half on each level
    c = {32'h0790_0000, 32'h0880_0000, 32'hFFF8_0000, 32'h0008_0000};
    send_block(c, ID_W'(1), 1'b0);
    c = {32'h8000_0000, 32'h0080_0000, 32'hFFF7_FFFF, 32'h0007_FFFF};
    send_block(c, ID_W'(2), 1'b1);
    wait_drained();

    // Back to back blocks, fixed latency and no output gaps
    lat_arm     = 1'b1;
    stream_left = 4 * L;
    stream_seen = 1'b0;
    stream_chk  = 1'b1;
    repeat (4) send_random_block();
    wait_drained();
    stream_chk = 1'b0;

    // Input gaps and output back-pressure
    gaps_on = 1'b1;
    bp_on   = 1'b1;
    repeat (40) send_random_block();
    wait_drained();

    // No extra level may still wait at the output
    if (!out_valid_o) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("output level left over after the last block");
    end
  end

endmodule

/* design/decomp_top.sv */
module decomp_top
  import decomp_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 s_rst_n,

  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic [BEAT_COEF_NB-1:0][MOD_Q_W-1:0] in_data_i,
  input  logic [ID_W-1:0]                      in_id_i,
  input  logic                                 in_eob_i,

  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output digit_t [COEF_NB-1:0]                 out_data_o,
  output logic                                 out_sol_o,
  output logic                                 out_eol_o,
  output logic [ID_W-1:0]                      out_id_o,
  output logic                                 out_eob_o
);

  side_t  in_side;
  logic   load;
  logic   step;
  digit_t [COEF_NB-1:0] digits;

  decomp_stream_if #(.payload_t(beat_t))  in_if ();
  decomp_stream_if #(.payload_t(beat_t))  beat_if ();
  decomp_stream_if #(.payload_t(block_t)) block_if ();
  decomp_stream_if #(.payload_t(level_t)) level_if ();
  decomp_stream_if #(.payload_t(level_t)) out_if ();

  // ====================
  // Input side
  // ====================
  assign in_side      = '{id: in_id_i, eob: in_eob_i};
  assign in_if.valid  = in_valid_i;
  assign in_if.data   = '{coef: in_data_i, side: in_side};
  assign in_if.side   = in_side;
  assign in_ready_o   = in_if.ready;

  pipe_stage #(.payload_t(beat_t)) u_in_stage (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .s_if    (in_if),
    .m_if    (beat_if)
  );

  chunk_gather u_gather (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .beat_s  (beat_if),
    .block_m (block_if)
  );

  // ====================
  // Decomposition
  // ====================
  decomp_ctrl u_ctrl (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .block_s  (block_if),
    .level_m  (level_if),
    .load_o   (load),
    .step_o   (step),
    .digits_i (digits)
  );

  balseq_lanes u_lanes (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .load_i   (load),
    .step_i   (step),
    .block_i  (block_if.data),
    .digits_o (digits)
  );

  pipe_stage #(.payload_t(level_t)) u_out_stage (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .s_if    (level_if),
    .m_if    (out_if)
  );

  // Output side
  assign out_if.ready = out_ready_i;
  assign out_valid_o  = out_if.valid;
  assign out_data_o   = out_if.data.digit;
  assign out_sol_o    = out_if.data.sol;
  assign out_eol_o    = out_if.data.eol;
  assign out_id_o     = out_if.side.id;
  assign out_eob_o    = out_if.side.eob;

endmodule

/* design/decomp_ctrl.sv */
module decomp_ctrl
  import decomp_pkg::*;
(
  input  logic                 clk,
  input  logic                 s_rst_n,
  decomp_stream_if.snk         block_s,
  decomp_stream_if.src         level_m,
  output logic                 load_o,
  output logic                 step_o,
  input  digit_t [COEF_NB-1:0] digits_i
);

  localparam int LVL_W = (L > 1) ? $clog2(L) : 1;

  logic             busy_q;
  logic             seen_q;
  logic [LVL_W-1:0] lvl_q;
  side_t            side_q;
  logic             last_lvl;
  logic             level_xfer;
  logic             accept;

  assign last_lvl   = (lvl_q == LVL_W'(L - 1));
  assign level_xfer = busy_q && level_m.ready;

  // Idle: take the block one cycle after it shows up
  // Busy: take the next one with the last level push
  assign block_s.ready = (!busy_q && seen_q) || (level_xfer && last_lvl);
  assign accept        = block_s.valid && block_s.ready;

  assign load_o = accept;
  assign step_o = level_xfer;

  // ====================
  // Level sequencing
  // ====================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy_q <= 1'b0;
      seen_q <= 1'b0;
      lvl_q  <= '0;
    end else begin
      seen_q <= block_s.valid && !accept;
      if (accept) begin
        busy_q <= 1'b1;
        lvl_q  <= '0;
      end else if (level_xfer) begin
        busy_q <= !last_lvl;
        lvl_q  <= last_lvl ? '0 : lvl_q + LVL_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      side_q <= block_s.side;
    end
  end

  assign level_m.valid      = busy_q;
  assign level_m.data.digit = digits_i;
  assign level_m.data.sol   = (lvl_q == '0);
  assign level_m.data.eol   = last_lvl;
  assign level_m.data.side  = side_q;
  assign level_m.side       = side_q;

endmodule

/* design/balseq_lanes.sv */
module balseq_lanes
  import decomp_pkg::*;
(
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 load_i,
  input  logic                 step_i,
  input  block_t               block_i,
  output digit_t [COEF_NB-1:0] digits_o
);

  localparam int HALF = 2 ** (B_W - 1);
  localparam int BASE = 2 ** B_W;

  logic [COEF_NB-1:0][REP_W-1:0] rem_q;
  logic [COEF_NB-1:0]            carry_q;
  logic [COEF_NB-1:0][REP_W-1:0] rem_nxt;
  logic [COEF_NB-1:0][B_W:0]     sum;
  logic [COEF_NB-1:0]            neg;

  // ====================
  // Digit of the level
  // ====================

  // Top bit of the next chunk breaks the tie at HALF
  always_comb begin
    for (int i = 0; i < COEF_NB; i++) begin
      rem_nxt[i]  = rem_q[i] >> B_W;
      sum[i]      = {1'b0, rem_q[i][B_W-1:0]} + (B_W+1)'(carry_q[i]);
      neg[i]      = (sum[i] > (B_W+1)'(HALF)) ||
                    ((sum[i] == (B_W+1)'(HALF)) && rem_nxt[i][B_W-1]);
      digits_o[i] = neg[i] ? sum[i] - (B_W+1)'(BASE) : sum[i];
    end
  end

  // Load takes priority over a step on the same edge
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      carry_q <= '0;
    end else if (load_i) begin
      carry_q <= '0;
    end else if (step_i) begin
      carry_q <= neg;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      rem_q <= block_i;
    end else if (step_i) begin
      rem_q <= rem_nxt;
    end
  end

endmodule

/* design/chunk_gather.sv */
module chunk_gather
  import decomp_pkg::*;
(
  input  logic         clk,
  input  logic         s_rst_n,
  decomp_stream_if.snk beat_s,
  decomp_stream_if.src block_m
);

  localparam int CNT_W = (CHUNK_NB > 1) ? $clog2(CHUNK_NB) : 1;

  logic [BEAT_COEF_NB-1:0][REP_W-1:0]         rep_beat;
  logic [BEAT_COEF_NB+COEF_NB-1:0][REP_W-1:0] shift_in;
  block_t                                     block_q;
  side_t                                      side_q;
  logic [CNT_W-1:0]                           cnt_q;
  logic                                       full_q;
  logic                                       beat_xfer;
  logic                                       last_beat;
  logic                                       block_xfer;

  closest_rep_round u_round (
    .coef_i (beat_s.data.coef),
    .rep_o  (rep_beat)
  );

  // Held block blocks the input unless it leaves now
  assign beat_s.ready = !full_q || block_m.ready;
  assign beat_xfer    = beat_s.valid && beat_s.ready;
  assign block_xfer   = block_m.valid && block_m.ready;
  assign last_beat    = (cnt_q == CNT_W'(CHUNK_NB - 1));

  // New beat enters the top slots, beat 0 ends lowest
  assign shift_in = {rep_beat, block_q};

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (beat_xfer) begin
        cnt_q <= last_beat ? '0 : cnt_q + CNT_W'(1);
      end
      if (beat_xfer && last_beat) begin
        full_q <= 1'b1;
      end else if (block_xfer) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_xfer) begin
      block_q <= shift_in[BEAT_COEF_NB +: COEF_NB];
    end
    // Block sideband comes from its last beat
    if (beat_xfer && last_beat) begin
      side_q <= beat_s.side;
    end
  end

  assign block_m.valid = full_q;
  assign block_m.data  = block_q;
  assign block_m.side  = side_q;

endmodule

/* design/closest_rep_round.sv */
module closest_rep_round
  import decomp_pkg::*;
(
  input  logic [BEAT_COEF_NB-1:0][MOD_Q_W-1:0] coef_i,
  output logic [BEAT_COEF_NB-1:0][REP_W-1:0]   rep_o
);

  // Position of the kept field inside a coefficient
  localparam int REP_OFS = MOD_Q_W - REP_W;

  logic [BEAT_COEF_NB-1:0] frac;

  // ====================
  // Round to nearest
  // ====================

  // Add the first dropped bit, wraps modulo 2^REP_W
  always_comb begin
    for (int i = 0; i < BEAT_COEF_NB; i++) begin
      frac[i]  = coef_i[i][REP_OFS-1];
      rep_o[i] = coef_i[i][REP_OFS +: REP_W] + REP_W'(frac[i]);
    end
  end

endmodule

/* design/pipe_stage.sv */
module pipe_stage
  import decomp_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic            clk,
  input  logic            s_rst_n,
  decomp_stream_if.snk    s_if,
  decomp_stream_if.src    m_if
);

  logic     valid_q;
  payload_t data_q;
  side_t    side_q;
  logic     load;

  // Free slot, or the held entry leaves on this edge
  assign s_if.ready = !valid_q || m_if.ready;
  assign load       = s_if.valid && s_if.ready;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      valid_q <= 1'b0;
    end else if (s_if.ready) begin
      valid_q <= s_if.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= s_if.data;
      side_q <= s_if.side;
    end
  end

  assign m_if.valid = valid_q;
  assign m_if.data  = data_q;
  assign m_if.side  = side_q;

endmodule

/* design/decomp_stream_if.sv */
interface decomp_stream_if
  import decomp_pkg::*;
#(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;
  side_t    side;

  // Producer side
  modport src (
    output valid,
    output data,
    output side,
    input  ready
  );

  // Consumer side
  modport snk (
    input  valid,
    input  data,
    input  side,
    output ready
  );

endinterface

/* design/decomp_pkg.sv */
`include "decomp_settings.svh"

package decomp_pkg;

  localparam int MOD_Q_W      = `DECOMP_MOD_Q_W;
  localparam int B_W          = `DECOMP_B_W;
  localparam int L            = `DECOMP_L;
  localparam int CHUNK_NB     = `DECOMP_CHUNK_NB;
  localparam int COEF_NB      = `DECOMP_COEF_NB;
  localparam int ID_W         = `DECOMP_ID_W;
  // Closest representation width and coefficients per beat
  localparam int REP_W        = L * B_W;
  localparam int BEAT_COEF_NB = COEF_NB / CHUNK_NB;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            eob;
  } side_t;

  typedef struct packed {
    logic [BEAT_COEF_NB-1:0][MOD_Q_W-1:0] coef;
    side_t                                side;
  } beat_t;

  typedef logic [COEF_NB-1:0][REP_W-1:0] block_t;

  // Two's complement digit
  typedef logic signed [B_W:0] digit_t;

  typedef struct packed {
    digit_t [COEF_NB-1:0] digit;
    logic                 sol;
    logic                 eol;
    side_t                side;
  } level_t;

endpackage

/* design/decomp_settings.svh */
`ifndef DECOMP_SETTINGS_SVH
`define DECOMP_SETTINGS_SVH

// ====================
// Decomposition setup
// ====================

// Torus coefficient width
`define DECOMP_MOD_Q_W 32
// Digit base width and number of levels
`define DECOMP_B_W 4
`define DECOMP_L 3
// Beats per block, COEF_NB must be a multiple of it
`define DECOMP_CHUNK_NB 2
`define DECOMP_COEF_NB 4
`define DECOMP_ID_W 4

`endif
